// File: hw/bus_pkg.sv
// memory bus package: default sizes, channel structs, bundled request/response, response codes
package bus_pkg;

  // default sizes, used to size module parameters
  parameter int unsigned ADDR_W = 32;
  parameter int unsigned BEAT_W = 64;
  parameter int unsigned ID_W   = 4;

  parameter logic [1:0] RESP_OKAY = 2'b00;

  // ------------------------------
  // channel payloads
  // ------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [ID_W-1:0]   id;
  } addr_chan_t;

  typedef struct packed {
    logic [BEAT_W-1:0]   data;
    logic [BEAT_W/8-1:0] strb;
    logic                last;
  } wdata_chan_t;

  typedef struct packed {
    logic [1:0]      resp;
    logic [ID_W-1:0] id;
  } bresp_chan_t;

  typedef struct packed {
    logic [BEAT_W-1:0] data;
    logic [1:0]        resp;
    logic [ID_W-1:0]   id;
    logic              last;
  } rdata_chan_t;

  // manager to subordinate
  typedef struct packed {
    logic        aw_valid;
    addr_chan_t  aw;
    logic        w_valid;
    wdata_chan_t w;
    logic        b_ready;
    logic        ar_valid;
    addr_chan_t  ar;
    logic        r_ready;
  } bus_req_t;

  // subordinate to manager
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    bresp_chan_t b;
    logic        ar_ready;
    logic        r_valid;
    rdata_chan_t r;
  } bus_rsp_t;

endpackage

// File: hw/line_pkg.sv
// cache-side package: line geometry, request kind, cache request and response structs
package line_pkg;

  // words per line, default for the BEATS module parameter
  parameter int unsigned BEATS = 4;

  // byte offset width of one line (BEATS * BEAT_W / 8 bytes)
  parameter int unsigned LINE_OFFSET = 5;

  typedef logic [BEATS-1:0][bus_pkg::BEAT_W-1:0]   line_t;
  typedef logic [BEATS-1:0][bus_pkg::BEAT_W/8-1:0] strb_line_t;

  typedef enum logic {
    SINGLE = 1'b0,
    LINE   = 1'b1
  } req_kind_e;

  // ------------------------------
  // cache request and response
  // ------------------------------
  typedef struct packed {
    logic                       we;
    req_kind_e                  kind;
    logic [bus_pkg::ADDR_W-1:0] addr;
    logic [1:0]                 size;
    logic [bus_pkg::ID_W-1:0]   id;
    line_t                      wdata;
    strb_line_t                 be;
  } cache_req_t;

  typedef struct packed {
    line_t                    rdata;
    logic [bus_pkg::ID_W-1:0] id;
  } cache_rsp_t;

endpackage

// File: hw/adapter_ctrl.sv
// adapter_ctrl: request acceptance FSM, engine start pulses, grant forwarding, completion
`timescale 1ns/10ps

module adapter_ctrl #(
  parameter int unsigned ID_W = bus_pkg::ID_W
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  line_pkg::cache_req_t req_i_data,
  input  logic                wr_gnt_i,
  input  logic                rd_gnt_i,
  input  logic                wr_done_i,
  input  logic                rd_done_i,
  input  logic [ID_W-1:0]     wr_id_i,
  input  logic [ID_W-1:0]     rd_id_i,
  output logic                start_wr_o,
  output logic                start_rd_o,
  output logic                gnt_o,
  output logic                valid_o,
  output logic [ID_W-1:0]     rsp_id_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    RESPOND
  } state_e;

  state_e          state_q;
  logic            wr_active_q;
  logic            start_wr_q;
  logic            start_rd_q;
  logic [ID_W-1:0] rsp_id_q;

  logic            eng_done;
  logic [ID_W-1:0] eng_id;

  // only the active engine is listened to
  assign eng_done = wr_active_q ? wr_done_i : rd_done_i;
  assign eng_id   = wr_active_q ? wr_id_i : rd_id_i;

  assign gnt_o      = wr_active_q ? wr_gnt_i : rd_gnt_i;
  assign start_wr_o = start_wr_q;
  assign start_rd_o = start_rd_q;
  assign valid_o    = (state_q == RESPOND);
  assign rsp_id_o   = rsp_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      wr_active_q <= 1'b0;
      start_wr_q  <= 1'b0;
      start_rd_q  <= 1'b0;
    end else begin
      start_wr_q <= 1'b0;
      start_rd_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_i) begin
            state_q     <= BUSY;
            wr_active_q <= req_i_data.we;
            start_wr_q  <= req_i_data.we;
            start_rd_q  <= !req_i_data.we;
          end
        end
        BUSY: begin
          if (eng_done) begin
            state_q <= RESPOND;
          end
        end
        // one-cycle completion pulse
        RESPOND: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == BUSY && eng_done) begin
      rsp_id_q <= eng_id;
    end
  end

endmodule

// File: hw/write_engine.sv
// write_engine: aw and w channel driver for single or burst writes, b response wait
`timescale 1ns/10ps

module write_engine #(
  parameter int unsigned BEATS  = line_pkg::BEATS,
  parameter int unsigned BEAT_W = bus_pkg::BEAT_W,
  parameter int unsigned ID_W   = bus_pkg::ID_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  line_pkg::cache_req_t req_data_i,
  input  logic                 aw_ready_i,
  input  logic                 w_ready_i,
  input  logic                 b_valid_i,
  input  bus_pkg::bresp_chan_t b_i,
  output logic                 aw_valid_o,
  output bus_pkg::addr_chan_t  aw_o,
  output logic                 w_valid_o,
  output bus_pkg::wdata_chan_t w_o,
  output logic                 b_ready_o,
  output logic                 gnt_o,
  output logic                 done_o,
  output logic [ID_W-1:0]      id_o
);

  import bus_pkg::*;
  import line_pkg::*;

  localparam int unsigned CNT_W   = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int unsigned BEAT_SZ = $clog2(BEAT_W / 8);

  logic             busy_q;
  logic             b_wait_q;
  logic             aw_done_q;
  logic             w_done_q;
  logic [CNT_W-1:0] cnt_q;

  logic             is_line;
  logic [CNT_W-1:0] last_idx;
  logic             aw_hs;
  logic             w_hs;
  logic             w_last_hs;
  logic             aw_fin;
  logic             w_fin;

  assign is_line  = (req_data_i.kind == LINE);
  assign last_idx = is_line ? CNT_W'(BEATS - 1) : '0;

  // ------------------------------
  // address channel
  // ------------------------------
  assign aw_valid_o = busy_q && !aw_done_q;
  assign aw_o.addr  = is_line ?
                      {req_data_i.addr[ADDR_W-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}} :
                      req_data_i.addr;
  assign aw_o.len   = is_line ? 8'(BEATS - 1) : 8'd0;
  assign aw_o.size  = is_line ? 3'(BEAT_SZ) : {1'b0, req_data_i.size};
  assign aw_o.id    = req_data_i.id;

  // ------------------------------
  // data channel
  // ------------------------------
  // a single write starts and ends at word 0
  assign w_valid_o = busy_q && !w_done_q;
  assign w_o.data  = req_data_i.wdata[cnt_q];
  assign w_o.strb  = req_data_i.be[cnt_q];
  assign w_o.last  = (cnt_q == last_idx);

  assign aw_hs     = aw_valid_o && aw_ready_i;
  assign w_hs      = w_valid_o && w_ready_i;
  assign w_last_hs = w_hs && w_o.last;
  assign aw_fin    = aw_done_q || aw_hs;
  assign w_fin     = w_done_q || w_last_hs;

  // address and data may finish in either order
  assign gnt_o = busy_q && aw_fin && w_fin;

  // ------------------------------
  // write response
  // ------------------------------
  assign b_ready_o = b_wait_q;
  assign done_o    = b_wait_q && b_valid_i;
  assign id_o      = b_i.id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      b_wait_q  <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      cnt_q     <= '0;
    end else begin
      if (start_i) begin
        busy_q    <= 1'b1;
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
        cnt_q     <= '0;
      end else if (busy_q) begin
        if (aw_hs) begin
          aw_done_q <= 1'b1;
        end
        if (w_last_hs) begin
          w_done_q <= 1'b1;
        end else if (w_hs) begin
          cnt_q <= cnt_q + 1'b1;
        end
        if (gnt_o) begin
          busy_q   <= 1'b0;
          b_wait_q <= 1'b1;
        end
      end
      if (done_o) begin
        b_wait_q <= 1'b0;
      end
    end
  end

endmodule

// File: hw/read_engine.sv
// read_engine: ar channel driver, line assembly from read beats, critical word flag
`timescale 1ns/10ps

module read_engine #(
  parameter int unsigned BEATS  = line_pkg::BEATS,
  parameter int unsigned BEAT_W = bus_pkg::BEAT_W,
  parameter int unsigned ID_W   = bus_pkg::ID_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  line_pkg::cache_req_t req_data_i,
  input  logic                 ar_ready_i,
  input  logic                 r_valid_i,
  input  bus_pkg::rdata_chan_t r_i,
  output logic                 ar_valid_o,
  output bus_pkg::addr_chan_t  ar_o,
  output logic                 r_ready_o,
  output line_pkg::line_t      line_o,
  output logic [BEAT_W-1:0]    crit_o,
  output logic                 crit_valid_o,
  output logic                 gnt_o,
  output logic                 done_o,
  output logic [ID_W-1:0]      id_o
);

  import bus_pkg::*;
  import line_pkg::*;

  localparam int unsigned CNT_W   = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int unsigned BEAT_SZ = $clog2(BEAT_W / 8);

  logic             ar_busy_q;
  logic             r_wait_q;
  logic             done_q;
  logic             is_line_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] offset_q;
  logic [ID_W-1:0]  id_q;
  line_t            line_q;

  logic             is_line;
  logic             r_hs;

  assign is_line = (req_data_i.kind == LINE);

  // a line read starts at the line base, a single read at the exact address
  assign ar_valid_o = ar_busy_q;
  assign ar_o.addr  = is_line ?
                      {req_data_i.addr[ADDR_W-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}} :
                      req_data_i.addr;
  assign ar_o.len   = is_line ? 8'(BEATS - 1) : 8'd0;
  assign ar_o.size  = is_line ? 3'(BEAT_SZ) : {1'b0, req_data_i.size};
  assign ar_o.id    = req_data_i.id;
  assign gnt_o      = ar_valid_o && ar_ready_i;

  assign r_ready_o = r_wait_q;
  assign r_hs      = r_valid_i && r_ready_o;

  // beat index matches the word that caused the request
  assign crit_valid_o = r_hs && is_line_q && (cnt_q == offset_q);
  assign crit_o       = r_i.data;

  assign line_o = line_q;
  assign done_o = done_q;
  assign id_o   = id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_busy_q <= 1'b0;
      r_wait_q  <= 1'b0;
      done_q    <= 1'b0;
      is_line_q <= 1'b0;
      cnt_q     <= '0;
      offset_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        ar_busy_q <= 1'b1;
      end else if (gnt_o) begin
        ar_busy_q <= 1'b0;
        r_wait_q  <= 1'b1;
        is_line_q <= is_line;
        cnt_q     <= '0;
        offset_q  <= req_data_i.addr[BEAT_SZ +: CNT_W];
      end
      if (r_hs) begin
        cnt_q <= cnt_q + 1'b1;
        if (r_i.last) begin
          r_wait_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  // line register and returned id
  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      line_q[is_line_q ? cnt_q : '0] <= r_i.data;
      if (r_i.last) begin
        id_q <= r_i.id;
      end
    end
  end

endmodule

// File: hw/axi_adapter.sv
// axi_adapter: top level with controller, write engine, read engine and bus merge
`timescale 1ns/10ps

module axi_adapter #(
  parameter int unsigned BEATS  = line_pkg::BEATS,
  parameter int unsigned BEAT_W = bus_pkg::BEAT_W,
  parameter int unsigned ID_W   = bus_pkg::ID_W
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  line_pkg::cache_req_t req_data_i,
  output logic                 gnt_o,
  output logic                 valid_o,
  output line_pkg::cache_rsp_t rsp_o,
  output logic [BEAT_W-1:0]    critical_word_o,
  output logic                 critical_word_valid_o,
  output bus_pkg::bus_req_t    bus_o,
  input  bus_pkg::bus_rsp_t    bus_i
);

  import bus_pkg::*;
  import line_pkg::*;

  logic            start_wr;
  logic            start_rd;
  logic            wr_gnt;
  logic            rd_gnt;
  logic            wr_done;
  logic            rd_done;
  logic [ID_W-1:0] wr_id;
  logic [ID_W-1:0] rd_id;
  logic [ID_W-1:0] rsp_id;
  line_t           rd_line;

  logic            aw_valid;
  logic            w_valid;
  logic            b_ready;
  logic            ar_valid;
  logic            r_ready;
  addr_chan_t      aw;
  addr_chan_t      ar;
  wdata_chan_t     w;

  adapter_ctrl #(
    .ID_W (ID_W)
  ) u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .req_i_data (req_data_i),
    .wr_gnt_i   (wr_gnt),
    .rd_gnt_i   (rd_gnt),
    .wr_done_i  (wr_done),
    .rd_done_i  (rd_done),
    .wr_id_i    (wr_id),
    .rd_id_i    (rd_id),
    .start_wr_o (start_wr),
    .start_rd_o (start_rd),
    .gnt_o      (gnt_o),
    .valid_o    (valid_o),
    .rsp_id_o   (rsp_id)
  );

  write_engine #(
    .BEATS  (BEATS),
    .BEAT_W (BEAT_W),
    .ID_W   (ID_W)
  ) u_wr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_wr),
    .req_data_i (req_data_i),
    .aw_ready_i (bus_i.aw_ready),
    .w_ready_i  (bus_i.w_ready),
    .b_valid_i  (bus_i.b_valid),
    .b_i        (bus_i.b),
    .aw_valid_o (aw_valid),
    .aw_o       (aw),
    .w_valid_o  (w_valid),
    .w_o        (w),
    .b_ready_o  (b_ready),
    .gnt_o      (wr_gnt),
    .done_o     (wr_done),
    .id_o       (wr_id)
  );

  read_engine #(
    .BEATS  (BEATS),
    .BEAT_W (BEAT_W),
    .ID_W   (ID_W)
  ) u_rd (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_rd),
    .req_data_i   (req_data_i),
    .ar_ready_i   (bus_i.ar_ready),
    .r_valid_i    (bus_i.r_valid),
    .r_i          (bus_i.r),
    .ar_valid_o   (ar_valid),
    .ar_o         (ar),
    .r_ready_o    (r_ready),
    .line_o       (rd_line),
    .crit_o       (critical_word_o),
    .crit_valid_o (critical_word_valid_o),
    .gnt_o        (rd_gnt),
    .done_o       (rd_done),
    .id_o         (rd_id)
  );

  // ------------------------------
  // bus merge and cache response
  // ------------------------------
  assign bus_o = '{
    aw_valid: aw_valid,
    aw:       aw,
    w_valid:  w_valid,
    w:        w,
    b_ready:  b_ready,
    ar_valid: ar_valid,
    ar:       ar,
    r_ready:  r_ready
  };

  assign rsp_o = '{rdata: rd_line, id: rsp_id};

endmodule

// File: sim/adapter_checker.sv
// adapter_checker: bus handshake, burst last and reset assertions, bound into axi_adapter
`timescale 1ns/10ps

module adapter_checker #(
  parameter int unsigned BEATS = line_pkg::BEATS
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 gnt_o,
  input logic                 valid_o,
  input logic                 critical_word_valid_o,
  input line_pkg::cache_req_t req_data_i,
  input bus_pkg::bus_req_t    bus_o,
  input bus_pkg::bus_rsp_t    bus_i
);

  import line_pkg::*;

  logic [7:0] w_cnt_q;
  logic       w_hs;

  assign w_hs = bus_o.w_valid && bus_i.w_ready;

  // write beats seen so far in the current burst
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_cnt_q <= '0;
    end else if (w_hs) begin
      w_cnt_q <= bus_o.w.last ? 8'd0 : w_cnt_q + 8'd1;
    end
  end

  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !gnt_o && !valid_o &&
    !critical_word_valid_o && !bus_o.aw_valid && !bus_o.w_valid && !bus_o.ar_valid)
    else $error("outputs active during reset");

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_o.aw_valid && !bus_i.aw_ready |=> bus_o.aw_valid && $stable(bus_o.aw))
    else $error("aw dropped or changed before ready");

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_o.w_valid && !bus_i.w_ready |=> bus_o.w_valid && $stable(bus_o.w))
    else $error("w dropped or changed before ready");

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_o.ar_valid && !bus_i.ar_ready |=> bus_o.ar_valid && $stable(bus_o.ar))
    else $error("ar dropped or changed before ready");

  // last on the final beat only, BEATS beats for a line write
  w_last_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_hs |-> bus_o.w.last == (w_cnt_q == ((req_data_i.kind == LINE) ? 8'(BEATS - 1) : 8'd0)))
    else $error("write last on wrong beat");

endmodule

bind axi_adapter adapter_checker #(
  .BEATS (BEATS)
) u_checker (
  .clk_i                 (clk_i),
  .rst_ni                (rst_ni),
  .gnt_o                 (gnt_o),
  .valid_o               (valid_o),
  .critical_word_valid_o (critical_word_valid_o),
  .req_data_i            (req_data_i),
  .bus_o                 (bus_o),
  .bus_i                 (bus_i)
);

// File: sim/tb_axi_adapter.sv
// axi_adapter testbench with clock, reset, bus slave memory, stimulus, reference model and compare
`timescale 1ns/10ps

module tb_axi_adapter;

  import bus_pkg::*;
  import line_pkg::*;

  localparam int          NUM_TXN = 200;
  localparam int          TIMEOUT = 200;
  localparam logic [31:0] BASE    = 32'h0000_2000;
  localparam logic [31:0] SEED    = 32'hc804_8352;

  // what the compare process expects for the transaction in flight
  typedef struct packed {
    logic            we;
    logic            is_line;
    logic [ID_W-1:0] id;
    logic [1:0]      offset;
    line_t           data;
  } expect_t;

  logic              clk_i;
  logic              rst_ni;
  logic              req;
  cache_req_t        req_data;
  logic              gnt;
  logic              valid;
  cache_rsp_t        rsp;
  logic [BEAT_W-1:0] crit_word;
  logic              crit_valid;
  bus_req_t          bus_req;
  bus_rsp_t          bus_rsp;

  logic [63:0] mem [64];
  logic [63:0] ref_mem [64];
  expect_t     exp_cur;
  int          gnt_cnt;
  int          done_cnt;
  int          crit_cnt;

  axi_adapter #(
    .BEATS  (BEATS),
    .BEAT_W (BEAT_W),
    .ID_W   (ID_W)
  ) UUT (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req),
    .req_data_i            (req_data),
    .gnt_o                 (gnt),
    .valid_o               (valid),
    .rsp_o                 (rsp),
    .critical_word_o       (crit_word),
    .critical_word_valid_o (crit_valid),
    .bus_o                 (bus_req),
    .bus_i                 (bus_rsp)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------
  // helpers and reference model
  // ------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // initial memory word built from its own byte address
  function automatic logic [63:0] fill_word(input int i);
    logic [31:0] a;
    a = BASE + 32'(i * 8);
    return {a, ~a};
  endfunction

  function automatic logic [63:0] merge_strobed(input logic [63:0] old_w, input logic [63:0] new_w,
                                                input logic [7:0] strb);
    logic [63:0] r;
    r = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  // line read gives the whole line and single read the word in slot 0
  function automatic line_t expected_read(input logic [3:0] ln, input logic [1:0] wd,
                                          input logic is_line);
    line_t l;
    l = '0;
    for (int k = 0; k < BEATS; k++) begin
      if (is_line) l[k] = ref_mem[{ln, 2'(k)}];
    end
    if (!is_line) l[0] = ref_mem[{ln, wd}];
    return l;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "wait expired");
  endtask

  // ------------------------------
  // bus slave with random ready and response delays
  // ------------------------------
  initial begin : bus_slave
    logic [31:0] s;
    logic [2:0]  vld;
    logic [2:0]  rdy;
    logic [2:0]  hs;
    int          dly [3];
    logic        b_hs;
    logic        r_hs;
    addr_chan_t  aw_s;
    addr_chan_t  ar_s;
    addr_chan_t  aw_q;
    addr_chan_t  ar_q;
    wdata_chan_t w_s;
    logic [63:0] wbuf [BEATS];
    logic [7:0]  sbuf [BEATS];
    int          wbeat;
    int          b_dly;
    int          r_dly;
    int          r_beat;
    logic        aw_have;
    logic        w_have;
    logic        b_pend;
    logic        r_pend;
    logic [5:0]  idx;
    s = SEED ^ 32'h5a5a_0001;
    rdy = '0;
    dly = '{-1, -1, -1};
    aw_q = '0;
    ar_q = '0;
    wbeat = 0;
    b_dly = 0;
    r_dly = 0;
    r_beat = 0;
    aw_have = 1'b0;
    w_have = 1'b0;
    b_pend = 1'b0;
    r_pend = 1'b0;
    bus_rsp = '0;
    for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
    forever begin
      // channel order in the vectors is aw, w, ar
      @(posedge clk_i);
      vld  = {bus_req.ar_valid, bus_req.w_valid, bus_req.aw_valid};
      hs   = vld & rdy;
      aw_s = bus_req.aw;
      w_s  = bus_req.w;
      ar_s = bus_req.ar;
      b_hs = bus_rsp.b_valid && bus_req.b_ready;
      r_hs = bus_rsp.r_valid && bus_req.r_ready;
      @(negedge clk_i);
      for (int i = 0; i < 3; i++) begin
        if (hs[i]) begin
          rdy[i] = 1'b0;
          dly[i] = -1;
        end else if (vld[i] && !rdy[i]) begin
          if (dly[i] < 0) begin
            s = lcg_next(s);
            dly[i] = int'(s[31:30]);
          end
          if (dly[i] == 0) rdy[i] = 1'b1;
          else dly[i]--;
        end
      end
      // every request here moves 8-byte beats
      if (hs[0]) begin
        check_value("write beat size", 64'(aw_s.size), 64'd3);
        aw_q = aw_s;
        aw_have = 1'b1;
      end
      if (hs[1] && wbeat < BEATS) begin
        wbuf[wbeat] = w_s.data;
        sbuf[wbeat] = w_s.strb;
        wbeat++;
        if (w_s.last) w_have = 1'b1;
      end
      // commit once both address and data have arrived in either order
      if (aw_have && w_have) begin
        check_value("write burst length", 64'(aw_q.len) + 64'd1, 64'(wbeat));
        idx = aw_q.addr[8:3];
        for (int k = 0; k < wbeat; k++) begin
          mem[idx + 6'(k)] = merge_strobed(mem[idx + 6'(k)], wbuf[k], sbuf[k]);
        end
        aw_have = 1'b0;
        w_have = 1'b0;
        wbeat = 0;
        b_pend = 1'b1;
        s = lcg_next(s);
        b_dly = int'(s[31:30]);
      end
      if (b_hs) begin
        bus_rsp.b_valid = 1'b0;
        b_pend = 1'b0;
      end
      if (b_pend && !bus_rsp.b_valid) begin
        if (b_dly == 0) begin
          bus_rsp.b_valid = 1'b1;
          bus_rsp.b = '{resp: RESP_OKAY, id: aw_q.id};
        end else b_dly--;
      end
      if (hs[2]) begin
        check_value("read beat size", 64'(ar_s.size), 64'd3);
        ar_q = ar_s;
        r_pend = 1'b1;
        r_beat = 0;
        s = lcg_next(s);
        r_dly = int'(s[31:30]);
      end
      if (r_hs) begin
        bus_rsp.r_valid = 1'b0;
        r_beat++;
        if (bus_rsp.r.last) r_pend = 1'b0;
        s = lcg_next(s);
        r_dly = int'(s[31:30]);
      end
      if (r_pend && !bus_rsp.r_valid) begin
        if (r_dly == 0) begin
          bus_rsp.r_valid = 1'b1;
          bus_rsp.r = '{data: mem[ar_q.addr[8:3] + 6'(r_beat)], resp: RESP_OKAY,
                        id: ar_q.id, last: (r_beat == int'(ar_q.len))};
        end else r_dly--;
      end
      bus_rsp.aw_ready = rdy[0];
      bus_rsp.w_ready  = rdy[1];
      bus_rsp.ar_ready = rdy[2];
    end
  end

  // ------------------------------
  // compare process
  // ------------------------------
  always @(posedge clk_i) begin : compare
    if (!rst_ni) begin
      gnt_cnt = 0;
      done_cnt = 0;
      crit_cnt = 0;
    end else begin
      if (gnt) begin
        check_value("single grant per request", 64'(gnt_cnt), 64'(done_cnt));
        gnt_cnt++;
      end
      if (crit_valid) begin
        check_value("critical word on line read", 64'({exp_cur.we, exp_cur.is_line}), 64'd1);
        check_value("critical word data", crit_word, exp_cur.data[exp_cur.offset]);
        crit_cnt++;
      end
      if (valid) begin
        check_value("grant before valid", 64'(gnt_cnt), 64'(done_cnt + 1));
        check_value("response id", 64'(rsp.id), 64'(exp_cur.id));
        if (!exp_cur.we && exp_cur.is_line) begin
          for (int k = 0; k < BEATS; k++) begin
            check_value("line read word", rsp.rdata[k], exp_cur.data[k]);
          end
          check_value("critical word pulse count", 64'(crit_cnt), 64'd1);
        end else if (!exp_cur.we) begin
          check_value("single read word", rsp.rdata[0], exp_cur.data[0]);
        end
        crit_cnt = 0;
        done_cnt++;
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin : stimulus
    logic [31:0] s;
    logic [3:0]  ln;
    logic [1:0]  wd;
    logic [63:0] word;
    int          t;
    int          g0;
    int          d0;
    s = SEED;
    req = 1'b0;
    req_data = '0;
    exp_cur = '0;
    rst_ni = 1'b0;
    for (int i = 0; i < 64; i++) ref_mem[i] = fill_word(i);
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    // nothing may move before the first request
    repeat (4) begin
      @(negedge clk_i);
      check_value("idle outputs", 64'({gnt, valid, crit_valid, bus_req.aw_valid, bus_req.w_valid,
                                       bus_req.b_ready, bus_req.ar_valid, bus_req.r_ready}), 64'd0);
    end
    for (int n = 0; n < NUM_TXN; n++) begin
      s = lcg_next(s);
      ln = s[29:26];
      wd = s[25:24];
      req_data.we   = s[31];
      req_data.kind = s[30] ? LINE : SINGLE;
      req_data.addr = BASE + {23'd0, ln, wd, 3'd0};
      req_data.size = 2'd3;
      req_data.id   = s[23:20];
      for (int k = 0; k < BEATS; k++) begin
        s = lcg_next(s);
        word[63:32] = s;
        s = lcg_next(s);
        word[31:0] = s;
        req_data.wdata[k] = word;
        s = lcg_next(s);
        req_data.be[k] = s[31:24];
      end
      exp_cur.we      = req_data.we;
      exp_cur.is_line = (req_data.kind == LINE);
      exp_cur.id      = req_data.id;
      exp_cur.offset  = wd;
      exp_cur.data    = '0;
      if (req_data.we && req_data.kind == LINE) begin
        for (int k = 0; k < BEATS; k++) begin
          ref_mem[{ln, 2'(k)}] = merge_strobed(ref_mem[{ln, 2'(k)}], req_data.wdata[k],
                                               req_data.be[k]);
        end
      end else if (req_data.we) begin
        ref_mem[{ln, wd}] = merge_strobed(ref_mem[{ln, wd}], req_data.wdata[0], req_data.be[0]);
      end else begin
        exp_cur.data = expected_read(ln, wd, exp_cur.is_line);
      end
      g0 = gnt_cnt;
      d0 = done_cnt;
      req = 1'b1;
      t = 0;
      while (gnt_cnt == g0) begin
        @(negedge clk_i);
        t++;
        if (t > TIMEOUT) report_timeout("grant");
      end
      req = 1'b0;
      t = 0;
      while (done_cnt == d0) begin
        @(negedge clk_i);
        t++;
        if (t > TIMEOUT) report_timeout("response valid");
      end
    end
    $display("TEST OK");
    $finish;
  end

endmodule

// File: compile.f
hw/bus_pkg.sv
hw/line_pkg.sv
hw/adapter_ctrl.sv
hw/write_engine.sv
hw/read_engine.sv
hw/axi_adapter.sv
sim/adapter_checker.sv
sim/tb_axi_adapter.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_axi_adapter -o tb_axi_adapter

out=$(./obj_dir/tb_axi_adapter 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST OK"; then
  exit 0
else
  exit 1
fi
